// ==== common/udp_ip_consts.svh ====
`ifndef UDP_IP_CONSTS_SVH
`define UDP_IP_CONSTS_SVH

// payload buffer depth is 2**AW.
`define UIP_FIFO_AW 6

`define UIP_UDP_HDR_LEN 8
`define UIP_IP_HDR_LEN 20

`define UIP_IP_VER_IHL 8'h45
`define UIP_IP_FLAGS 16'h4000
`define UIP_IP_TTL 8'h40
`define UIP_IP_PROTO_UDP 8'h11

`endif

// ==== common/udp_ip_pkg.sv ====
package udp_ip_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] len_t;
    typedef logic [15:0] port_t;
    typedef logic [31:0] ip_addr_t;

    // header states share the upper nibble 1.
    typedef enum logic [7:0] {
        U_IDLE = 8'h00,
        U_WAIT = 8'h01,
        U_WORK = 8'h02,
        U_DONE = 8'h03,
        U_HD00 = 8'h10,
        U_HD01 = 8'h11,
        U_HD02 = 8'h12,
        U_HD03 = 8'h13,
        U_HD04 = 8'h14,
        U_HD05 = 8'h15,
        U_HD06 = 8'h16,
        U_HD07 = 8'h17
    } udp_state_t;

    typedef enum logic [2:0] {
        I_IDLE = 3'd0,
        I_WAIT = 3'd1,
        I_HDR  = 3'd2,
        I_UDP  = 3'd3,
        I_DONE = 3'd4
    } ip_state_t;

endpackage

// ==== rtl/payload_fifo.sv ====
`timescale 1ns/1ps
`include "udp_ip_consts.svh"

module payload_fifo #(
    parameter int AW = `UIP_FIFO_AW
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  udp_ip_pkg::byte_t wr_data,
    input  logic              rd_en,
    output udp_ip_pkg::byte_t rd_data,
    output logic              full,
    output logic              empty
);

    udp_ip_pkg::byte_t mem [2**AW];
    logic [AW:0]       wr_ptr;
    logic [AW:0]       rd_ptr;

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]}); // wrapped once more.
    assign rd_data = mem[rd_ptr[AW-1:0]]; // head always shown.

    always_ff @(posedge clk) begin
        if (wr_en && !full) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr_en && full))
        else $error("payload_fifo: write while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd_en && empty))
        else $error("payload_fifo: read while empty, payload shorter than payload_len");

endmodule

// ==== udp/udp_tx.sv ====
`timescale 1ns/1ps
`include "udp_ip_consts.svh"

module udp_tx (
    input  logic              clk,
    input  logic              rst,
    input  logic              fs,
    output logic              fd,
    input  udp_ip_pkg::port_t src_port,
    input  udp_ip_pkg::port_t dst_port,
    input  udp_ip_pkg::len_t  udp_len,
    output logic              fifo_rd_en,
    input  udp_ip_pkg::byte_t fifo_rd_data,
    output udp_ip_pkg::byte_t udp_data,
    output logic              udp_valid
);

    localparam udp_ip_pkg::len_t CHECKSUM = 16'h0000; // sent as zero.

    udp_ip_pkg::udp_state_t state;
    udp_ip_pkg::udp_state_t next_state;
    udp_ip_pkg::len_t       cnt;
    udp_ip_pkg::len_t       dlen;

    assign fd         = (state == udp_ip_pkg::U_DONE);
    assign fifo_rd_en = (state == udp_ip_pkg::U_WORK);

    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= udp_ip_pkg::U_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            udp_ip_pkg::U_IDLE: next_state = udp_ip_pkg::U_WAIT;
            udp_ip_pkg::U_WAIT: next_state = fs ? udp_ip_pkg::U_HD00 : udp_ip_pkg::U_WAIT;
            udp_ip_pkg::U_HD00: next_state = udp_ip_pkg::U_HD01;
            udp_ip_pkg::U_HD01: next_state = udp_ip_pkg::U_HD02;
            udp_ip_pkg::U_HD02: next_state = udp_ip_pkg::U_HD03;
            udp_ip_pkg::U_HD03: next_state = udp_ip_pkg::U_HD04;
            udp_ip_pkg::U_HD04: next_state = udp_ip_pkg::U_HD05;
            udp_ip_pkg::U_HD05: next_state = udp_ip_pkg::U_HD06;
            udp_ip_pkg::U_HD06: next_state = udp_ip_pkg::U_HD07;
            udp_ip_pkg::U_HD07: begin
                // an empty datagram skips the payload.
                next_state = (dlen == '0) ? udp_ip_pkg::U_DONE : udp_ip_pkg::U_WORK;
            end
            udp_ip_pkg::U_WORK: begin
                next_state = (cnt >= dlen - 16'd1) ? udp_ip_pkg::U_DONE : udp_ip_pkg::U_WORK;
            end
            udp_ip_pkg::U_DONE: next_state = fs ? udp_ip_pkg::U_DONE : udp_ip_pkg::U_WAIT;
            default:            next_state = udp_ip_pkg::U_IDLE;
        endcase
    end

    ////////////////////

    always_ff @(posedge clk) begin
        case (state)
            udp_ip_pkg::U_HD00: udp_data <= src_port[15:8];
            udp_ip_pkg::U_HD01: udp_data <= src_port[7:0];
            udp_ip_pkg::U_HD02: udp_data <= dst_port[15:8];
            udp_ip_pkg::U_HD03: udp_data <= dst_port[7:0];
            udp_ip_pkg::U_HD04: udp_data <= udp_len[15:8];
            udp_ip_pkg::U_HD05: udp_data <= udp_len[7:0];
            udp_ip_pkg::U_HD06: udp_data <= CHECKSUM[15:8];
            udp_ip_pkg::U_HD07: udp_data <= CHECKSUM[7:0];
            udp_ip_pkg::U_WORK: udp_data <= fifo_rd_data;
            default:            udp_data <= 8'h00;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            udp_valid <= 1'b0;
            dlen      <= '0;
            cnt       <= '0;
        end else begin
            udp_valid <= (state[7:4] == 4'h1) || (state == udp_ip_pkg::U_WORK);
            if (state == udp_ip_pkg::U_HD00) begin
                dlen <= udp_len - 16'(`UIP_UDP_HDR_LEN); // payload bytes only.
            end
            if (state == udp_ip_pkg::U_WORK) begin
                cnt <= cnt + 16'd1;
            end else begin
                cnt <= '0;
            end
        end
    end

endmodule

// ==== ip/ip_checksum.sv ====
`timescale 1ns/1ps
`include "udp_ip_consts.svh"

module ip_checksum (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  udp_ip_pkg::len_t     total_len,
    input  udp_ip_pkg::len_t     ident,
    input  udp_ip_pkg::ip_addr_t src_ip,
    input  udp_ip_pkg::ip_addr_t dst_ip,
    output udp_ip_pkg::len_t     checksum,
    output logic                 done
);

    localparam udp_ip_pkg::len_t WORD0 = {`UIP_IP_VER_IHL, 8'h00}; // version, ihl, tos.

    logic [16:0]      acc;
    logic [16:0]      sum;
    udp_ip_pkg::len_t word;
    logic [3:0]       idx;
    logic             busy;

    always_comb begin
        case (idx)
            4'd1:    word = total_len;
            4'd2:    word = ident;
            4'd3:    word = `UIP_IP_FLAGS;
            4'd4:    word = {`UIP_IP_TTL, `UIP_IP_PROTO_UDP};
            4'd6:    word = src_ip[31:16];
            4'd7:    word = src_ip[15:0];
            4'd8:    word = dst_ip[31:16];
            4'd9:    word = dst_ip[15:0];
            default: word = 16'h0000; // word 5 is the checksum field.
        endcase
    end

    assign sum = {1'b0, acc[15:0]} + {16'h0000, acc[16]} + {1'b0, word}; // end-around carry.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            idx  <= '0;
            done <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            idx  <= 4'd1;
            done <= 1'b0;
        end else if (busy) begin
            idx <= idx + 4'd1;
            if (idx == 4'd9) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= {1'b0, WORD0};
        end else if (busy) begin
            acc <= sum;
        end
        if (busy && idx == 4'd9) begin
            checksum <= ~(sum[15:0] + {15'h0000, sum[16]}); // last fold cannot carry.
        end
    end

endmodule

// ==== ip/ip_tx.sv ====
`timescale 1ns/1ps
`include "udp_ip_consts.svh"

module ip_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fs,
    output logic                 fd,
    input  udp_ip_pkg::ip_addr_t src_ip,
    input  udp_ip_pkg::ip_addr_t dst_ip,
    input  udp_ip_pkg::len_t     payload_len,
    output logic                 udp_fs,
    input  logic                 udp_fd,
    output udp_ip_pkg::len_t     udp_len,
    input  udp_ip_pkg::byte_t    udp_data,
    input  logic                 udp_valid,
    output udp_ip_pkg::byte_t    ip_data,
    output logic                 ip_valid
);

    localparam logic [15:0] IP_FLAGS = `UIP_IP_FLAGS;
    localparam logic [4:0]  HDR_LAST = 5'(`UIP_IP_HDR_LEN - 1);
    localparam logic [4:0]  CS_BYTE  = 5'd10; // checksum high byte.

    udp_ip_pkg::ip_state_t state;
    logic [4:0]            hcnt;
    udp_ip_pkg::len_t      ident;
    udp_ip_pkg::len_t      total_len;
    udp_ip_pkg::len_t      checksum;
    logic                  cs_start;
    logic                  cs_done;
    logic                  hdr_go;
    udp_ip_pkg::byte_t     hdr_byte;

    assign total_len = payload_len + 16'(`UIP_IP_HDR_LEN + `UIP_UDP_HDR_LEN);
    assign udp_len   = payload_len + 16'(`UIP_UDP_HDR_LEN);

    assign fd       = (state == udp_ip_pkg::I_DONE);
    assign udp_fs   = (state == udp_ip_pkg::I_UDP);
    assign cs_start = (state == udp_ip_pkg::I_HDR) && (hcnt == 5'd0);
    assign hdr_go   = (hcnt != CS_BYTE) || cs_done; // hold until the sum is ready.

    assign ip_valid = ((state == udp_ip_pkg::I_HDR) && hdr_go) ||
                      ((state == udp_ip_pkg::I_UDP) && udp_valid);
    assign ip_data  = (state == udp_ip_pkg::I_HDR) ? hdr_byte : udp_data;

    ip_checksum i_checksum (
        .clk       (clk),
        .rst       (rst),
        .start     (cs_start),
        .total_len (total_len),
        .ident     (ident),
        .src_ip    (src_ip),
        .dst_ip    (dst_ip),
        .checksum  (checksum),
        .done      (cs_done)
    );

    ////////////////////

    always_comb begin
        case (hcnt)
            5'd0:    hdr_byte = `UIP_IP_VER_IHL;
            5'd1:    hdr_byte = 8'h00;
            5'd2:    hdr_byte = total_len[15:8];
            5'd3:    hdr_byte = total_len[7:0];
            5'd4:    hdr_byte = ident[15:8];
            5'd5:    hdr_byte = ident[7:0];
            5'd6:    hdr_byte = IP_FLAGS[15:8];
            5'd7:    hdr_byte = IP_FLAGS[7:0];
            5'd8:    hdr_byte = `UIP_IP_TTL;
            5'd9:    hdr_byte = `UIP_IP_PROTO_UDP;
            5'd10:   hdr_byte = checksum[15:8];
            5'd11:   hdr_byte = checksum[7:0];
            5'd12:   hdr_byte = src_ip[31:24];
            5'd13:   hdr_byte = src_ip[23:16];
            5'd14:   hdr_byte = src_ip[15:8];
            5'd15:   hdr_byte = src_ip[7:0];
            5'd16:   hdr_byte = dst_ip[31:24];
            5'd17:   hdr_byte = dst_ip[23:16];
            5'd18:   hdr_byte = dst_ip[15:8];
            default: hdr_byte = dst_ip[7:0];
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= udp_ip_pkg::I_IDLE;
            hcnt  <= '0;
            ident <= '0;
        end else begin
            case (state)
                udp_ip_pkg::I_IDLE: state <= udp_ip_pkg::I_WAIT;
                udp_ip_pkg::I_WAIT: begin
                    hcnt <= '0;
                    if (fs) begin
                        state <= udp_ip_pkg::I_HDR;
                    end
                end
                udp_ip_pkg::I_HDR: begin
                    if (hdr_go) begin
                        hcnt <= hcnt + 5'd1;
                        if (hcnt == HDR_LAST) begin
                            state <= udp_ip_pkg::I_UDP;
                        end
                    end
                end
                udp_ip_pkg::I_UDP: begin
                    if (udp_fd) begin
                        ident <= ident + 16'd1; // next frame id.
                        state <= udp_ip_pkg::I_DONE;
                    end
                end
                udp_ip_pkg::I_DONE: begin
                    if (!fs) begin
                        state <= udp_ip_pkg::I_WAIT;
                    end
                end
                default: state <= udp_ip_pkg::I_IDLE;
            endcase
        end
    end

    // the checksum unit finishes exactly when byte 10 is due.
    a_cs_in_time: assert property (@(posedge clk) disable iff (rst)
        (state == udp_ip_pkg::I_HDR && hcnt == CS_BYTE) |-> cs_done)
        else $error("ip_tx: checksum not ready for header byte 10");

endmodule

// ==== rtl/tx_out.sv ====
`timescale 1ns/1ps

module tx_out (
    input  logic              clk,
    input  logic              rst,
    input  udp_ip_pkg::byte_t ip_data,
    input  logic              ip_valid,
    input  logic              fd,
    output udp_ip_pkg::byte_t tx_data,
    output logic              tx_valid,
    output logic              tx_sop,
    output logic              tx_eop
);

    logic frame_open; // bytes of this frame already passed.
    logic in_frame;   // output side, sop seen and eop not yet.

    // fd rises together with the delayed last byte.
    assign tx_eop = tx_valid && fd;

    always_ff @(posedge clk) begin
        tx_data <= ip_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_valid   <= 1'b0;
            tx_sop     <= 1'b0;
            frame_open <= 1'b0;
            in_frame   <= 1'b0;
        end else begin
            tx_valid <= ip_valid;
            tx_sop   <= ip_valid && !frame_open;
            if (ip_valid) begin
                frame_open <= 1'b1;
            end else if (fd) begin
                frame_open <= 1'b0;
            end
            if (tx_sop) begin
                in_frame <= 1'b1;
            end else if (tx_eop) begin
                in_frame <= 1'b0;
            end
        end
    end

    a_no_nested_sop: assert property (@(posedge clk) disable iff (rst) !(tx_sop && in_frame))
        else $error("tx_out: start of packet inside an open frame");

endmodule

// ==== rtl/udp_ip_tx.sv ====
`timescale 1ns/1ps

module udp_ip_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_en,
    input  udp_ip_pkg::byte_t    wr_data,
    output logic                 full,
    input  logic                 fs,
    output logic                 fd,
    input  udp_ip_pkg::ip_addr_t src_ip,
    input  udp_ip_pkg::ip_addr_t dst_ip,
    input  udp_ip_pkg::port_t    src_port,
    input  udp_ip_pkg::port_t    dst_port,
    input  udp_ip_pkg::len_t     payload_len,
    output udp_ip_pkg::byte_t    tx_data,
    output logic                 tx_valid,
    output logic                 tx_sop,
    output logic                 tx_eop
);

    logic              fifo_rd_en;
    udp_ip_pkg::byte_t fifo_rd_data;
    logic              udp_fs;
    logic              udp_fd;
    udp_ip_pkg::len_t  udp_len;
    udp_ip_pkg::byte_t udp_data;
    logic              udp_valid;
    udp_ip_pkg::byte_t ip_data;
    logic              ip_valid;

    payload_fifo i_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .full    (full),
        .empty   ()
    );

    ip_tx i_ip (
        .clk         (clk),
        .rst         (rst),
        .fs          (fs),
        .fd          (fd),
        .src_ip      (src_ip),
        .dst_ip      (dst_ip),
        .payload_len (payload_len),
        .udp_fs      (udp_fs),
        .udp_fd      (udp_fd),
        .udp_len     (udp_len),
        .udp_data    (udp_data),
        .udp_valid   (udp_valid),
        .ip_data     (ip_data),
        .ip_valid    (ip_valid)
    );

    udp_tx i_udp (
        .clk          (clk),
        .rst          (rst),
        .fs           (udp_fs),
        .fd           (udp_fd),
        .src_port     (src_port),
        .dst_port     (dst_port),
        .udp_len      (udp_len),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .udp_data     (udp_data),
        .udp_valid    (udp_valid)
    );

    tx_out i_out (
        .clk      (clk),
        .rst      (rst),
        .ip_data  (ip_data),
        .ip_valid (ip_valid),
        .fd       (fd),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_sop   (tx_sop),
        .tx_eop   (tx_eop)
    );

endmodule

// ==== verif/tb_udp_ip_tx_tasks.svh ====
`ifndef TB_UDP_IP_TX_TASKS_SVH
`define TB_UDP_IP_TX_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
        err_count++;
        $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
    end
endtask

task automatic report_failure(input string what);
    err_count++;
    $display("FAILURE at %0t: %s", $time, what);
endtask

task automatic push_word(input logic [15:0] w);
    exp_bytes.push_back(w[15:8]); // network order.
    exp_bytes.push_back(w[7:0]);
endtask

////////////////////
// reference packet

task automatic build_expected(input int len, input int ident);
    logic [31:0]      sum;
    udp_ip_pkg::len_t csum;
    int               i;
    exp_bytes.delete();
    push_word({`UIP_IP_VER_IHL, 8'h00});
    push_word(16'(len + `UIP_IP_HDR_LEN + `UIP_UDP_HDR_LEN));
    push_word(16'(ident));
    push_word(`UIP_IP_FLAGS);
    push_word({`UIP_IP_TTL, `UIP_IP_PROTO_UDP});
    push_word(16'h0000); // checksum, filled below.
    push_word(src_ip[31:16]);
    push_word(src_ip[15:0]);
    push_word(dst_ip[31:16]);
    push_word(dst_ip[15:0]);
    sum = '0;
    for (i = 0; i < `UIP_IP_HDR_LEN; i += 2) begin
        sum = sum + {16'h0000, exp_bytes[i], exp_bytes[i + 1]};
    end
    sum  = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    sum  = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    csum = ~sum[15:0];
    exp_bytes[10] = csum[15:8];
    exp_bytes[11] = csum[7:0];
    push_word(src_port);
    push_word(dst_port);
    push_word(16'(len + `UIP_UDP_HDR_LEN));
    push_word(16'h0000); // udp checksum unused.
    foreach (payload[k]) begin
        exp_bytes.push_back(payload[k]);
    end
endtask

task automatic compare_frame(input int len);
    int i;
    build_expected(len, frame_count);
    check_value("byte count", 32'(exp_bytes.size()), 32'(got_bytes.size()));
    for (i = 0; i < got_bytes.size() && i < exp_bytes.size(); i++) begin
        check_value($sformatf("tx_data[%0d]", i), 32'(exp_bytes[i]), 32'(got_bytes[i]));
        check_value($sformatf("tx_sop[%0d]", i), 32'(i == 0), 32'(got_sop[i]));
        check_value($sformatf("tx_eop[%0d]", i), 32'(i == exp_bytes.size() - 1),
                    32'(got_eop[i]));
    end
    got_bytes.delete();
    got_sop.delete();
    got_eop.delete();
    frame_count++;
endtask

////////////////////
// stimulus

task automatic apply_reset();
    @(posedge clk);
    rst   <= 1'b1;
    wr_en <= 1'b0;
    fs    <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    got_bytes.delete();
    got_sop.delete();
    got_eop.delete();
    frame_count = 0;
endtask

task automatic pick_fields();
    @(posedge clk);
    src_ip   <= $random(seed);
    dst_ip   <= $random(seed);
    src_port <= 16'($random(seed));
    dst_port <= 16'($random(seed));
endtask

task automatic load_payload(input int len);
    udp_ip_pkg::byte_t b;
    int                k;
    payload.delete();
    for (k = 0; k < len; k++) begin
        b = 8'($random(seed));
        payload.push_back(b);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_data <= b;
    end
    @(posedge clk);
    wr_en <= 1'b0;
endtask

// start a frame, hold fs a while after fd, then release it.
task automatic run_frame(input int len, input int hold);
    int n;
    @(posedge clk);
    payload_len <= 16'(len);
    fs          <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!fd && n < FRAME_WAIT) begin
        @(negedge clk);
        n++;
    end
    if (!fd) begin
        report_failure("fd did not rise after the frame was started");
    end
    repeat (hold) begin
        @(negedge clk);
        check_value("fd", 32'd1, 32'(fd));
    end
    @(posedge clk);
    fs <= 1'b0;
    @(negedge clk);
    check_value("fd", 32'd1, 32'(fd)); // falls one cycle later.
    @(negedge clk);
    check_value("fd", 32'd0, 32'(fd));
endtask

////////////////////
// tests

task automatic single_frame();
    apply_reset();
    @(posedge clk);
    src_ip   <= 32'hc0a8_0001;
    dst_ip   <= 32'hc0a8_00ff;
    src_port <= 16'd1234;
    dst_port <= 16'd80;
    load_payload(4);
    run_frame(4, 2);
    compare_frame(4);
endtask

task automatic fd_protocol();
    apply_reset();
    check_value("fd", 32'd0, 32'(fd));
    pick_fields();
    load_payload(10);
    check_value("fd", 32'd0, 32'(fd));
    run_frame(10, 6);
    compare_frame(10);
    repeat (10) @(negedge clk);
    check_value("bytes between frames", 32'd0, 32'(got_bytes.size()));
    check_value("fd", 32'd0, 32'(fd));
endtask

task automatic random_frames();
    int f;
    int len;
    apply_reset();
    for (f = 0; f < 8; f++) begin
        len = 1 + int'({$random(seed)} % 40);
        pick_fields();
        load_payload(len);
        run_frame(len, 1);
        compare_frame(len);
    end
endtask

task automatic buffer_full();
    apply_reset();
    pick_fields();
    load_payload(1 << `UIP_FIFO_AW);
    @(negedge clk);
    check_value("full", 32'd1, 32'(full));
    run_frame(1 << `UIP_FIFO_AW, 1);
    check_value("full", 32'd0, 32'(full));
    compare_frame(1 << `UIP_FIFO_AW);
endtask

task automatic reset_mid_frame();
    int n;
    apply_reset();
    pick_fields();
    load_payload(1 << `UIP_FIFO_AW); // buffer still full when the reset hits.
    @(posedge clk);
    payload_len <= 16'(1 << `UIP_FIFO_AW);
    fs          <= 1'b1;
    n = 0;
    while (got_bytes.size() < `UIP_IP_HDR_LEN && n < FRAME_WAIT) begin
        @(negedge clk);
        n++;
    end
    if (got_bytes.size() < `UIP_IP_HDR_LEN) begin
        report_failure("frame did not send its IP header before the reset");
    end
    apply_reset();
    check_value("tx_valid", 32'd0, 32'(tx_valid));
    check_value("tx_sop", 32'd0, 32'(tx_sop));
    check_value("tx_eop", 32'd0, 32'(tx_eop));
    check_value("fd", 32'd0, 32'(fd));
    check_value("full", 32'd0, 32'(full));
    pick_fields();
    load_payload(20);
    run_frame(20, 1);
    compare_frame(20); // identification restarts at 0.
endtask

`endif

// ==== verif/tb_udp_ip_tx.sv ====
`timescale 1ns/1ps
`include "udp_ip_consts.svh"

module tb_udp_ip_tx;

    localparam int NUM_FRAMES     = 13;
    localparam int FRAME_WAIT     = 200; // cycles allowed per frame.
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_WAIT + 1000;

    logic                 clk;
    logic                 rst;
    logic                 wr_en;
    udp_ip_pkg::byte_t    wr_data;
    logic                 full;
    logic                 fs;
    logic                 fd;
    udp_ip_pkg::ip_addr_t src_ip;
    udp_ip_pkg::ip_addr_t dst_ip;
    udp_ip_pkg::port_t    src_port;
    udp_ip_pkg::port_t    dst_port;
    udp_ip_pkg::len_t     payload_len;
    udp_ip_pkg::byte_t    tx_data;
    logic                 tx_valid;
    logic                 tx_sop;
    logic                 tx_eop;

    integer               seed = 32667;
    int                   err_count;
    int                   check_count;
    int                   frame_count;
    udp_ip_pkg::byte_t    payload [$];
    udp_ip_pkg::byte_t    exp_bytes [$];
    udp_ip_pkg::byte_t    got_bytes [$];
    logic                 got_sop [$];
    logic                 got_eop [$];

    udp_ip_tx i_dut (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .full        (full),
        .fs          (fs),
        .fd          (fd),
        .src_ip      (src_ip),
        .dst_ip      (dst_ip),
        .src_port    (src_port),
        .dst_port    (dst_port),
        .payload_len (payload_len),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .tx_sop      (tx_sop),
        .tx_eop      (tx_eop)
    );

    always #50 clk = ~clk;

    // output collector, sampled mid-cycle.
    always @(negedge clk) begin
        if (tx_valid) begin
            got_bytes.push_back(tx_data);
            got_sop.push_back(tx_sop);
            got_eop.push_back(tx_eop);
        end
    end

    `include "tb_udp_ip_tx_tasks.svh"

    ////////////////////

    initial begin
        clk         = 1'b0;
        err_count   = 0;
        check_count = 0;
        frame_count = 0;
        rst         <= 1'b1;
        wr_en       <= 1'b0;
        wr_data     <= 8'h00;
        fs          <= 1'b0;
        src_ip      <= '0;
        dst_ip      <= '0;
        src_port    <= '0;
        dst_port    <= '0;
        payload_len <= '0;
        single_frame();
        fd_protocol();
        random_frames();
        buffer_full();
        reset_mid_frame();
        repeat (5) @(posedge clk);
        $display("done: %0d errors in %0d checks", err_count, check_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== udp_ip_tx.f ====
+incdir+common
+incdir+verif
common/udp_ip_pkg.sv
rtl/payload_fifo.sv
udp/udp_tx.sv
ip/ip_checksum.sv
ip/ip_tx.sv
rtl/tx_out.sv
rtl/udp_ip_tx.sv
verif/tb_udp_ip_tx.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_udp_ip_tx
FILELIST = udp_ip_tx.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR  = obj_dir
PASS_MSG = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
